// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

  //////////////////////////////////////////////////
  // Widths and field codes
  //////////////////////////////////////////////////

  localparam int instrWidth = 32;                  // RV32 instruction word

  // Major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opFence  = 7'b0001111;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opSystem = 7'b1110011;

  localparam logic [6:0] funct7Zero = 7'b0000000;  // Most R-type ops
  localparam logic [6:0] funct7Alt  = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] funct7Mdu  = 7'b0000001;  // mul/div group

  localparam logic [2:0] f3Add  = 3'b000;          // Also address generation
  localparam logic [2:0] f3Sll  = 3'b001;
  localparam logic [2:0] f3Slt  = 3'b010;
  localparam logic [2:0] f3Sltu = 3'b011;
  localparam logic [2:0] f3Srl  = 3'b101;          // srl and sra
  localparam logic [2:0] f3Priv = 3'b000;          // ecall, ebreak, xret, wfi

  // Immediate formats
  localparam logic [2:0] immI = 3'b000;
  localparam logic [2:0] immS = 3'b001;
  localparam logic [2:0] immB = 3'b010;
  localparam logic [2:0] immJ = 3'b011;
  localparam logic [2:0] immU = 3'b100;

  // Writeback result select
  localparam logic [2:0] resAlu = 3'b000;
  localparam logic [2:0] resMem = 3'b001;
  localparam logic [2:0] resCsr = 3'b010;
  localparam logic [2:0] resMdu = 3'b011;

  //////////////////////////////////////////////////
  // Instruction views
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] op;
  } rTypeFields_t;

  typedef struct packed {
    logic [11:0] imm12;                            // CSR address or privileged code
    logic [4:0]  rs1;                              // zimm in the immediate CSR forms
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  op;
  } iTypeFields_t;

  typedef union packed {
    rTypeFields_t rType;
    iTypeFields_t iType;
  } instrWord_t;

  // Formats whose funct fields still need checking
  typedef enum logic [2:0] {
    classNone, classLoad, classStore, classOpImm,
    classOp, classBranch, classJalr, classSystem
  } opClass_t;

  typedef struct packed {
    logic load;
    logic store;
    logic opImm;
    logic op;
    logic branch;
    logic jalr;
    logic system;
  } functOk_t;

  //////////////////////////////////////////////////
  // Control bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [2:0] immSrc;
    logic       jump;
    logic       branch;
    logic       illegal;
    logic       instrValid;
  } decodeCtrl_t;

  typedef struct packed {
    logic [2:0] aluSelect;
    logic       aluSrcA;
    logic       aluSrcB;
    logic       aluResultSrc;
    logic       subArith;
    logic       branchSigned;
    logic       memRead;
    logic       mdu;
    logic       intDiv;
    logic       csrRead;
    logic [2:0] funct3;
    logic       instrValid;
  } execCtrl_t;

  typedef struct packed {
    logic       regWrite;
    logic [2:0] resultSrc;
    logic [1:0] memRw;                             // [1] read, [0] write
    logic       csrRead;
    logic       csrWrite;
    logic       privileged;
    logic [2:0] funct3;
    logic       instrValid;
    logic       csrWriteFence;
  } memCtrl_t;

  typedef struct packed {
    logic       regWrite;
    logic [2:0] resultSrc;
  } wbCtrl_t;

  typedef struct packed {
    logic       regWrite;
    logic [2:0] immSrc;
    logic       aluSrcA;
    logic       aluSrcB;
    logic [1:0] memRw;
    logic [2:0] resultSrc;
    logic       branch;
    logic       aluOp;                             // 0 means address generation
    logic       jump;
    logic       aluResultSrc;
    logic       csrRead;
    logic       privileged;
    logic       mdu;
    logic       illegal;
  } baseCtrl_t;

endpackage

// ==== hw/opcodeDecoder.sv ====
`timescale 1ns/100ps

module opcodeDecoder (
  input  ctrlPkg::instrWord_t instrD,              // Instruction in Decode
  output ctrlPkg::baseCtrl_t  base,                // Raw control bits, before funct check
  output ctrlPkg::opClass_t   opClass              // Format for the funct checker result
);
  import ctrlPkg::*;

  logic [6:0] op;                                  // Major opcode
  logic [2:0] funct3;
  logic       mulDiv;                              // OP opcode carrying an M extension op

  assign op     = instrD.rType.op;
  assign funct3 = instrD.rType.funct3;
  assign mulDiv = (instrD.rType.funct7 == funct7Mdu);

  //////////////////////////////////////////////////
  // Main decode table
  //////////////////////////////////////////////////

  // Field order:
  // regWrite_immSrc_aluSrcA_aluSrcB_memRw_resultSrc_branch_aluOp_jump_aluResultSrc_
  // csrRead_privileged_mdu_illegal
  always_comb begin
    base = baseCtrl_t'(19'b0_000_0_0_00_000_0_0_0_0_0_0_0_1);        // Unknown opcode
    case (op)
      opLoad:   base = baseCtrl_t'(19'b1_000_0_1_10_001_0_0_0_0_0_0_0_0);
      opFence:  base = baseCtrl_t'(19'b0_000_0_0_00_000_0_0_0_0_0_0_0_0); // Plain nop
      opOpImm:  base = baseCtrl_t'(19'b1_000_0_1_00_000_0_1_0_0_0_0_0_0);
      opAuipc:  base = baseCtrl_t'(19'b1_100_1_1_00_000_0_0_0_0_0_0_0_0);
      opStore:  base = baseCtrl_t'(19'b0_001_0_1_01_000_0_0_0_0_0_0_0_0);
      opOp: begin
        if (mulDiv)
          base = baseCtrl_t'(19'b1_000_0_0_00_011_0_0_0_0_0_0_1_0);  // mul/div
        else
          base = baseCtrl_t'(19'b1_000_0_0_00_000_0_1_0_0_0_0_0_0);  // R-type ALU
      end
      opLui:    base = baseCtrl_t'(19'b1_100_0_1_00_000_0_0_0_1_0_0_0_0);
      opBranch: base = baseCtrl_t'(19'b0_010_1_1_00_000_1_0_0_0_0_0_0_0);
      opJalr:   base = baseCtrl_t'(19'b1_000_0_1_00_000_0_0_1_1_0_0_0_0);
      opJal:    base = baseCtrl_t'(19'b1_011_1_1_00_000_0_0_1_1_0_0_0_0);
      opSystem: begin
        if (funct3 == f3Priv)
          base = baseCtrl_t'(19'b0_000_0_0_00_000_0_0_0_0_0_1_0_0);  // Privileged group
        else
          base = baseCtrl_t'(19'b1_000_0_0_00_010_0_0_0_0_1_0_0_0);  // CSR access
      end
      default: ;
    endcase
  end

  // Class selects which legality flag applies
  always_comb begin
    case (op)
      opLoad:   opClass = classLoad;
      opStore:  opClass = classStore;
      opOpImm:  opClass = classOpImm;
      opOp:     opClass = classOp;
      opBranch: opClass = classBranch;
      opJalr:   opClass = classJalr;
      opSystem: opClass = classSystem;
      default:  opClass = classNone;               // No funct fields to check
    endcase
  end

endmodule

// ==== hw/functChecker.sv ====
`timescale 1ns/100ps

module functChecker (
  input  ctrlPkg::instrWord_t instrD,              // Instruction in Decode
  output ctrlPkg::functOk_t   functOk,             // Legality per format
  output logic                subArithRaw,         // sub, sra, slt, sltu before aluOp gating
  output logic                csrWriteRaw          // CSR op would really write
);
  import ctrlPkg::*;

  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       f7Zero, f7Alt;                       // funct7 patterns for base ops
  logic       shiftOk;                             // slli, srli, srai encodings
  logic       privForm, csrForm;                   // System sub-groups
  logic       zeroSrc;                             // rs1 or zimm is zero

  assign funct7 = instrD.rType.funct7;
  assign funct3 = instrD.rType.funct3;
  assign f7Zero = (funct7 == funct7Zero);
  assign f7Alt  = (funct7 == funct7Alt);

  //////////////////////////////////////////////////
  // Legality per format
  //////////////////////////////////////////////////

  assign shiftOk = (funct3 == f3Sll & f7Zero) | (funct3 == f3Srl & (f7Zero | f7Alt));

  assign functOk.opImm  = shiftOk | (funct3 != f3Sll & funct3 != f3Srl);
  assign functOk.op     = f7Zero | (funct7 == funct7Mdu)
                        | ((funct3 == f3Add | funct3 == f3Srl) & f7Alt); // Bit 5 only here
  assign functOk.load   = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010)
                        | (funct3 == 3'b100) | (funct3 == 3'b101);      // lb lh lw lbu lhu
  assign functOk.store  = (funct3 == 3'b000) | (funct3 == 3'b001) | (funct3 == 3'b010);
  assign functOk.branch = (funct3[2:1] != 2'b01);  // 010 and 011 unused
  assign functOk.jalr   = (funct3 == 3'b000);

  // System group uses the I-type view
  assign privForm       = (instrD.iType.funct3 == f3Priv);
  assign csrForm        = (instrD.iType.funct3[1:0] != 2'b00);
  assign functOk.system = privForm | csrForm;      // 100 reserved

  //////////////////////////////////////////////////
  // Operand and CSR hints
  //////////////////////////////////////////////////

  // op bit 5 separates sub from addi
  assign subArithRaw = (funct3 == f3Add & funct7[5] & instrD.rType.op[5])
                     | (funct3 == f3Srl & funct7[5])
                     | (funct3 == f3Slt)
                     | (funct3 == f3Sltu);

  // Set or clear with zero leaves the CSR alone
  assign zeroSrc     = (instrD.iType.rs1 == 5'd0);
  assign csrWriteRaw = ~(zeroSrc & instrD.iType.funct3[1]);

endmodule

// ==== hw/pipeControl.sv ====
`timescale 1ns/100ps

module pipeControl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stallD, flushD,    // Decode hold and clear
  input  logic                  stallE, flushE,    // Execute hold and clear
  input  logic                  stallM, flushM,    // Memory hold and clear
  input  logic                  stallW, flushW,    // Writeback hold and clear
  input  ctrlPkg::instrWord_t   instrD,            // Instruction in Decode
  input  logic [1:0]            flagsE,            // Comparator {eq, lt}
  input  ctrlPkg::baseCtrl_t    base,              // From the opcode decoder
  input  ctrlPkg::opClass_t     opClass,
  input  ctrlPkg::functOk_t     functOk,           // From the funct checker
  input  logic                  subArithRaw,
  input  logic                  csrWriteRaw,
  output ctrlPkg::decodeCtrl_t  decodeCtrl,
  output ctrlPkg::execCtrl_t    execCtrl,
  output ctrlPkg::memCtrl_t     memCtrl,
  output ctrlPkg::wbCtrl_t      wbCtrl,
  output logic                  pcSrcE,            // Redirect fetch on jump or taken branch
  output logic                  storeStallD        // Hold Decode behind a store
);
  import ctrlPkg::*;

  // Execute register also carries bits bound for Memory
  typedef struct packed {
    logic [2:0] aluSelect;
    logic       aluSrcA;
    logic       aluSrcB;
    logic       aluResultSrc;
    logic       subArith;
    logic       regWrite;
    logic [2:0] resultSrc;
    logic [1:0] memRw;
    logic       jump;
    logic       branch;
    logic       mdu;
    logic       csrRead;
    logic       csrWrite;
    logic       privileged;
    logic [2:0] funct3;
    logic       instrValid;
  } execReg_t;

  logic       classOk;                             // Funct fields legal for this format
  logic       illegalD;
  logic       validD;                              // Decode slot holds an instruction
  logic [1:0] memRwD;                              // Squashed memory access
  execReg_t   execNext, eReg;
  logic       flagE;                               // eq or lt picked by funct3[2]

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    case (opClass)
      classLoad:   classOk = functOk.load;
      classStore:  classOk = functOk.store;
      classOpImm:  classOk = functOk.opImm;
      classOp:     classOk = functOk.op;
      classBranch: classOk = functOk.branch;
      classJalr:   classOk = functOk.jalr;
      classSystem: classOk = functOk.system;
      default:     classOk = 1'b1;
    endcase
  end

  assign illegalD = base.illegal | ~classOk;
  assign memRwD   = illegalD ? 2'b00 : base.memRw;

  // Illegal ops lose every side effect
  assign execNext = '{
    aluSelect:    base.aluOp ? instrD.rType.funct3 : f3Add,  // Add for addresses
    aluSrcA:      base.aluSrcA,
    aluSrcB:      base.aluSrcB,
    aluResultSrc: base.aluResultSrc,
    subArith:     base.aluOp & subArithRaw,
    regWrite:     base.regWrite & ~illegalD,
    resultSrc:    base.resultSrc,
    memRw:        memRwD,
    jump:         base.jump & ~illegalD,
    branch:       base.branch & ~illegalD,
    mdu:          base.mdu,
    csrRead:      base.csrRead,
    csrWrite:     base.csrRead & csrWriteRaw & ~illegalD,
    privileged:   base.privileged,
    funct3:       instrD.rType.funct3,
    instrValid:   validD
  };

  assign decodeCtrl = '{
    immSrc:     base.immSrc,
    jump:       execNext.jump,
    branch:     execNext.branch,
    illegal:    illegalD,
    instrValid: validD
  };

  assign storeStallD = eReg.memRw[0] & (|memRwD);  // Store in E, any access in D

  //////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////

  // Flush wins over stall in every stage
  always_ff @(posedge clk) begin
    if (reset | flushD) validD <= 1'b0;
    else if (~stallD)   validD <= 1'b1;

    if (reset | flushE) eReg <= '0;
    else if (~stallE)   eReg <= execNext;

    if (reset | flushM) memCtrl <= '0;
    else if (~stallM)   memCtrl <= '{
      regWrite:      eReg.regWrite,
      resultSrc:     eReg.resultSrc,
      memRw:         eReg.memRw,
      csrRead:       eReg.csrRead,
      csrWrite:      eReg.csrWrite,
      privileged:    eReg.privileged,
      funct3:        eReg.funct3,
      instrValid:    eReg.instrValid,
      csrWriteFence: eReg.csrWrite               // Younger stages flushed after a CSR write
    };

    if (reset | flushW) wbCtrl <= '0;
    else if (~stallW)   wbCtrl <= '{regWrite: memCtrl.regWrite, resultSrc: memCtrl.resultSrc};
  end

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  assign flagE  = eReg.funct3[2] ? flagsE[0] : flagsE[1];              // blt/bge use lt
  assign pcSrcE = eReg.jump | (eReg.branch & (flagE ^ eReg.funct3[0])); // Bit 0 inverts

  assign execCtrl = '{
    aluSelect:    eReg.aluSelect,
    aluSrcA:      eReg.aluSrcA,
    aluSrcB:      eReg.aluSrcB,
    aluResultSrc: eReg.aluResultSrc,
    subArith:     eReg.subArith,
    branchSigned: eReg.branch & (eReg.funct3[2:1] != 2'b11),  // Not bltu/bgeu
    memRead:      eReg.memRw[1],
    mdu:          eReg.mdu,
    intDiv:       eReg.mdu & eReg.funct3[2],                 // div, divu, rem, remu
    csrRead:      eReg.csrRead,
    funct3:       eReg.funct3,
    instrValid:   eReg.instrValid
  };

endmodule

// ==== hw/controller.sv ====
`timescale 1ns/100ps

module controller (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stallD, flushD,
  input  logic                         stallE, flushE,
  input  logic                         stallM, flushM,
  input  logic                         stallW, flushW,
  input  logic [ctrlPkg::instrWidth-1:0] instrD,   // Raw instruction word in Decode
  input  logic [1:0]                   flagsE,     // {eq, lt}
  output ctrlPkg::decodeCtrl_t         decodeCtrl,
  output ctrlPkg::execCtrl_t           execCtrl,
  output ctrlPkg::memCtrl_t            memCtrl,
  output ctrlPkg::wbCtrl_t             wbCtrl,
  output logic                         pcSrcE,
  output logic                         storeStallD
);
  import ctrlPkg::*;

  baseCtrl_t base;                                 // Opcode table result
  opClass_t  opClass;
  functOk_t  functOk;                              // Funct field legality
  logic      subArithRaw;
  logic      csrWriteRaw;

  // Both decoders see the same word
  opcodeDecoder opcodeDecoder_i (
    .instrD  (instrD),
    .base    (base),
    .opClass (opClass)
  );

  functChecker functChecker_i (
    .instrD      (instrD),
    .functOk     (functOk),
    .subArithRaw (subArithRaw),
    .csrWriteRaw (csrWriteRaw)
  );

  pipeControl pipeControl_i (
    .clk, .reset,
    .stallD, .flushD, .stallE, .flushE,
    .stallM, .flushM, .stallW, .flushW,
    .instrD      (instrD),
    .flagsE      (flagsE),
    .base        (base),
    .opClass     (opClass),
    .functOk     (functOk),
    .subArithRaw (subArithRaw),
    .csrWriteRaw (csrWriteRaw),
    .decodeCtrl  (decodeCtrl),
    .execCtrl    (execCtrl),
    .memCtrl     (memCtrl),
    .wbCtrl      (wbCtrl),
    .pcSrcE      (pcSrcE),
    .storeStallD (storeStallD)
  );

endmodule

// ==== dv/controllerSva.sv ====
`timescale 1ns/100ps

module controllerSva (
  input logic                 clk,
  input logic                 reset,
  input logic                 flushD, flushE, flushM, flushW,
  input ctrlPkg::instrWord_t  instrD,              // Instruction in Decode
  input ctrlPkg::decodeCtrl_t decodeCtrl,
  input ctrlPkg::execCtrl_t   execCtrl,
  input ctrlPkg::memCtrl_t    memCtrl,
  input ctrlPkg::wbCtrl_t     wbCtrl,
  input logic                 storeStallD,
  input logic                 storeE               // E register holds a store
);
  import ctrlPkg::*;

  int   failCount = 0;                             // Assertion failures so far
  logic loadStoreD;                                // Legal load or store in D

  assign loadStoreD = ((instrD.rType.op == opLoad) || (instrD.rType.op == opStore))
                      && !decodeCtrl.illegal;

  // Store in E blocks any memory access in D
  storeStall: assert property (@(posedge clk) disable iff (reset)
    storeStallD == (storeE && loadStoreD))
    else begin
      $error("storeStallD does not match the store in E and the access in D");
      failCount++;
    end

  //////////////////////////////////////////////////
  // Flushed stages are empty one cycle later
  //////////////////////////////////////////////////

  flushDecode: assert property (@(posedge clk) flushD |=> !decodeCtrl.instrValid)
    else begin
      $error("Decode still valid after flushD");
      failCount++;
    end
  flushExec: assert property (@(posedge clk) flushE |=> (execCtrl == '0))
    else begin
      $error("Execute control not cleared after flushE");
      failCount++;
    end
  flushMem: assert property (@(posedge clk) flushM |=> (memCtrl == '0))
    else begin
      $error("Memory control not cleared after flushM");
      failCount++;
    end
  flushWb: assert property (@(posedge clk) flushW |=> (wbCtrl == '0))
    else begin
      $error("Writeback control not cleared after flushW");
      failCount++;
    end

  // Nothing valid or writing right after reset
  resetState: assert property (@(posedge clk) reset |=>
    (!decodeCtrl.instrValid && !decodeCtrl.jump && !decodeCtrl.branch
     && !execCtrl.instrValid && !memCtrl.instrValid && !memCtrl.regWrite
     && (memCtrl.memRw == 2'b00) && !memCtrl.csrWrite && !wbCtrl.regWrite))
    else begin
      $error("Control state not cleared by reset");
      failCount++;
    end

endmodule

// ==== dv/controllerTb.sv ====
`timescale 1ns/100ps

module controllerTb;
  import ctrlPkg::*;

  localparam int resetCycles = 16;
  localparam int testCycles  = 2000;
  localparam int cycleLimit  = resetCycles + testCycles + 984;   // Margin up to 3000

  // Expected control of one instruction on its way down the pipe
  typedef struct packed {
    decodeCtrl_t dec;
    execCtrl_t   exe;
    memCtrl_t    mem;
    logic        jump;
    logic        branch;
  } refCtrl_t;

  logic                  clk, reset;
  logic                  stallD, flushD, stallE, flushE;
  logic                  stallM, flushM, stallW, flushW;
  logic [instrWidth-1:0] instrD;
  logic [1:0]            flagsE;                   // {eq, lt}
  decodeCtrl_t           decodeCtrl;
  execCtrl_t             execCtrl;
  memCtrl_t              memCtrl;
  wbCtrl_t               wbCtrl;
  logic                  pcSrcE, storeStallD;

  logic [15:0] lfsrState  = 16'd83;                // Seed
  logic        checking   = 1'b0;                  // Set once reset is released
  int          cycleCount = 0;
  refCtrl_t    eModel;                             // Model stage registers
  memCtrl_t    mModel;
  wbCtrl_t     wModel;
  logic        validModel;

  // Legal opcodes first, then unused, AMO, FP load and OP-32
  logic [6:0] opTable [0:15] = '{opLoad, opFence, opOpImm, opAuipc, opStore, opOp,
    opLui, opBranch, opJalr, opJal, opSystem, 7'b0000000, 7'b1111111, 7'b0101111,
    7'b0000111, 7'b0111011};

  controller controller_i (.*);

  bind pipeControl controllerSva controllerSva_i (
    .clk (clk), .reset (reset),
    .flushD (flushD), .flushE (flushE), .flushM (flushM), .flushW (flushW),
    .instrD (instrD),
    .decodeCtrl (decodeCtrl), .execCtrl (execCtrl), .memCtrl (memCtrl), .wbCtrl (wbCtrl),
    .storeStallD (storeStallD),
    .storeE (eReg.memRw[0])
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                         // 10 ns period
  end

  ////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);             // One step per bit
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] makeInstr();
    logic [6:0] op, f7;
    logic [4:0] rs1, rs2, rd;
    logic [2:0] f3;
    op  = opTable[4'(randBits(4))];
    f3  = 3'(randBits(3));
    case (2'(randBits(2)))                         // Bias funct7 toward known patterns
      2'd0:    f7 = 7'b0000000;
      2'd1:    f7 = 7'b0100000;
      2'd2:    f7 = 7'b0000001;
      default: f7 = 7'(randBits(7));
    endcase
    rs1 = (randBits(2) == 0) ? 5'd0 : 5'(randBits(5));  // Zero source for CSR set/clear
    rs2 = 5'(randBits(5));
    rd  = 5'(randBits(5));
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  ////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////

  function automatic refCtrl_t decodeRef(input logic [31:0] instr, input logic valid);
    refCtrl_t   r;
    logic [6:0] op, f7;
    logic [2:0] f3, immSrc, resSrc;
    logic [1:0] memRw;
    logic       regWr, srcA, srcB, aluOp, aluRes, csrRd, priv, mdu, jump, br;
    logic       known, legal, illegal, subRaw, csrWr;
    op = instr[6:0];
    f3 = instr[14:12];
    f7 = instr[31:25];
    {regWr, srcA, srcB, aluOp, aluRes, csrRd, priv, mdu, jump, br} = '0;
    immSrc = immI;
    resSrc = resAlu;
    memRw  = 2'b00;
    known  = 1'b1;
    legal  = 1'b1;
    case (op)
      opLoad: begin
        {regWr, srcB, memRw, resSrc} = {2'b11, 2'b10, resMem};
        legal = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);   // lb lh lw lbu lhu
      end
      opFence: ;                                   // Legal nop
      opOpImm: begin
        {regWr, srcB, aluOp} = 3'b111;
        if (f3 == 3'd1) legal = (f7 == 7'h00);   // slli
        else if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
      end
      opAuipc: {regWr, srcA, srcB, immSrc} = {3'b111, immU};
      opStore: begin
        {immSrc, srcB, memRw} = {immS, 1'b1, 2'b01};
        legal = (f3 < 3'd3);
      end
      opOp: begin
        regWr = 1'b1;
        legal = (f7 == 7'h00) || (f7 == 7'h01) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
        if (f7 == 7'h01) {mdu, resSrc} = {1'b1, resMdu};
        else aluOp = 1'b1;
      end
      opLui:    {regWr, immSrc, srcB, aluRes} = {1'b1, immU, 2'b11};
      opBranch: begin
        {immSrc, srcA, srcB, br} = {immB, 3'b111};
        legal = (f3 != 3'd2) && (f3 != 3'd3);
      end
      opJalr: begin
        {regWr, srcB, jump, aluRes} = 4'b1111;
        legal = (f3 == 3'd0);
      end
      opJal:    {regWr, immSrc, srcA, srcB, jump, aluRes} = {1'b1, immJ, 4'b1111};
      opSystem: begin
        if (f3 == 3'd0) priv = 1'b1;             // ecall, ebreak, xret, wfi
        else {regWr, resSrc, csrRd} = {1'b1, resCsr, 1'b1};
        legal = (f3 != 3'd4);
      end
      default: known = 1'b0;
    endcase
    illegal = !known || !legal;
    subRaw  = (f3 == 3'd0 && f7[5] && op == opOp) || (f3 == 3'd5 && f7[5])
            || (f3 == 3'd2) || (f3 == 3'd3);           // sub, sra, slt, sltu
    csrWr   = csrRd && !(instr[19:15] == 5'd0 && f3[1]) && !illegal;
    if (illegal) {regWr, memRw, jump, br} = '0;  // No side effects
    r.dec = '{immSrc: immSrc, jump: jump, branch: br, illegal: illegal, instrValid: valid};
    r.exe = '{aluSelect: aluOp ? f3 : 3'b000, aluSrcA: srcA, aluSrcB: srcB,
      aluResultSrc: aluRes, subArith: aluOp && subRaw,
      branchSigned: br && (f3[2:1] != 2'b11), memRead: memRw[1], mdu: mdu,
      intDiv: mdu && f3[2], csrRead: csrRd, funct3: f3, instrValid: valid};
    r.mem = '{regWrite: regWr, resultSrc: resSrc, memRw: memRw, csrRead: csrRd,
      csrWrite: csrWr, privileged: priv, funct3: f3, instrValid: valid,
      csrWriteFence: csrWr};
    r.jump   = jump;
    r.branch = br;
    return r;
  endfunction

  // beq/bne compare eq, blt/bge/bltu/bgeu compare lt, funct3[0] inverts
  function automatic logic pcSrcRef(input refCtrl_t e, input logic [1:0] flags);
    logic cond;
    cond = e.exe.funct3[2] ? flags[0] : flags[1];
    return e.jump || (e.branch && (cond ^ e.exe.funct3[0]));
  endfunction

  // Stage registers, flush before stall
  always @(posedge clk) begin
    if (reset) begin
      eModel     = '0;
      mModel     = '0;
      wModel     = '0;
      validModel = 1'b0;
    end else begin
      if (flushW) wModel = '0;
      else if (!stallW) wModel = '{regWrite: mModel.regWrite, resultSrc: mModel.resultSrc};
      if (flushM) mModel = '0;
      else if (!stallM) mModel = eModel.mem;
      if (flushE) eModel = '0;
      else if (!stallE) eModel = decodeRef(instrD, validModel);
      if (flushD) validModel = 1'b0;
      else if (!stallD) validModel = 1'b1;
    end
  end

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////

  task automatic reportMismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("CHECKS FAILED");
    $fatal(1, "Mismatch on %s", what);
  endtask

  task automatic checkDecode(input decodeCtrl_t got, input decodeCtrl_t exp);
    if (got !== exp) reportMismatch("decodeCtrl", 32'(got), 32'(exp));
  endtask

  task automatic checkExec(input execCtrl_t got, input execCtrl_t exp);
    if (got !== exp) reportMismatch("execCtrl", 32'(got), 32'(exp));
  endtask

  task automatic checkMem(input memCtrl_t got, input memCtrl_t exp);
    if (got !== exp) reportMismatch("memCtrl", 32'(got), 32'(exp));
  endtask

  task automatic checkWb(input wbCtrl_t got, input wbCtrl_t exp);
    if (got !== exp) reportMismatch("wbCtrl", 32'(got), 32'(exp));
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp) reportMismatch(what, 32'(got), 32'(exp));
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    refCtrl_t dNow;
    if (controller_i.pipeControl_i.controllerSva_i.failCount != 0) begin
      $display("A bound assertion failed before %0t ns", $time);
      $display("CHECKS FAILED");
      $fatal(1, "Assertion failure");
    end else if (checking) begin
      dNow = decodeRef(instrD, validModel);
      checkDecode(decodeCtrl, dNow.dec);
      checkExec(execCtrl, eModel.exe);
      checkMem(memCtrl, mModel);
      checkWb(wbCtrl, wModel);
      checkFlag("pcSrcE", pcSrcE, pcSrcRef(eModel, flagsE));
      checkFlag("storeStallD", storeStallD, eModel.mem.memRw[0] && (dNow.mem.memRw != 2'b00));
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  task automatic driveCycle();
    stallD = (randBits(3) == 0);                   // About one cycle in eight each
    flushD = (randBits(3) == 0);
    stallE = (randBits(3) == 0);
    flushE = (randBits(3) == 0);
    stallM = (randBits(3) == 0);
    flushM = (randBits(3) == 0);
    stallW = (randBits(3) == 0);
    flushW = (randBits(3) == 0);
    flagsE = 2'(randBits(2));
    if (!stallD) instrD = makeInstr();            // Held Decode keeps its word
  endtask

  initial begin
    reset  = 1'b1;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    instrD = 32'h0000_0013;                        // addi x0, x0, 0
    flagsE = 2'b00;
    repeat (resetCycles) @(posedge clk);
    #1 reset = 1'b0;
    checking = 1'b1;
    repeat (testCycles) begin
      @(posedge clk);
      #1 driveCycle();
    end
    @(posedge clk);
    #1;
    if (controller_i.pipeControl_i.controllerSva_i.failCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/ctrlPkg.sv
hw/opcodeDecoder.sv
hw/functChecker.sv
hw/pipeControl.sv
hw/controller.sv
dv/controllerSva.sv
dv/controllerTb.sv
